// ==== exec_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared widths, types and operation codes for the execution slice.
// Operation codes are per unit, so the same op value means different
// things to the ALU and to the multiplier.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package exec_pkg;

    // Widths
    localparam int XLEN = 32;
    localparam int REG_ADDR_WIDTH = 5;
    localparam int ID_WIDTH = 4;
    localparam int OP_WIDTH = 3;
    localparam int MUL_STAGES = 3;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [ID_WIDTH-1:0] id_t;
    typedef logic [OP_WIDTH-1:0] op_t;
    typedef logic unit_sel_t;

    // ALU operations, shifts use rs2[4:0], SLT is signed
    localparam op_t ALU_ADD = 3'd0;
    localparam op_t ALU_SUB = 3'd1;
    localparam op_t ALU_AND = 3'd2;
    localparam op_t ALU_OR  = 3'd3;
    localparam op_t ALU_XOR = 3'd4;
    localparam op_t ALU_SLL = 3'd5;
    localparam op_t ALU_SRL = 3'd6;
    localparam op_t ALU_SLT = 3'd7;

    // Multiplier operations on the unsigned product
    localparam op_t MUL_LO = 3'd0;
    localparam op_t MUL_HU = 3'd1;

    // Unit select
    localparam unit_sel_t UNIT_ALU = 1'b0;
    localparam unit_sel_t UNIT_MUL = 1'b1;

endpackage

`default_nettype wire

// ==== unit_issue_if.sv ====
//////////////////////////////////////////////////////////////////////
// One decoded instruction from dispatch to an execution unit.
// new_request is a strobe, only raised while ready is high.
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface unit_issue_if;

    logic new_request;
    logic ready;
    exec_pkg::id_t id;
    exec_pkg::reg_addr_t rd;
    exec_pkg::op_t op;
    exec_pkg::data_t rs1;
    exec_pkg::data_t rs2;

    modport dispatch (output new_request, id, rd, op, rs1, rs2, input ready);
    modport unit (input new_request, id, rd, op, rs1, rs2, output ready);

endinterface

`default_nettype wire

// ==== unit_wb_if.sv ====
//////////////////////////////////////////////////////////////////////
// One result from an execution unit to writeback.
// Result is held while done is high, and leaves on the ack cycle.
//////////////////////////////////////////////////////////////////////

`default_nettype none

interface unit_wb_if;

    logic done;
    logic ack;
    exec_pkg::id_t id;
    exec_pkg::reg_addr_t rd;
    exec_pkg::data_t rd_data;

    modport unit (output done, id, rd, rd_data, input ack);
    modport writeback (input done, id, rd, rd_data, output ack);

endinterface

`default_nettype wire

// ==== issue_dispatch.sv ====
//////////////////////////////////////////////////////////////////////
// Combinational unit dispatch. The instruction is taken when
// issue_valid and issue_ready are both high; issue_ready is the
// ready of whichever unit issue_unit selects.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module issue_dispatch (
    input  logic                  issue_valid,
    input  exec_pkg::unit_sel_t   issue_unit,
    input  exec_pkg::op_t         issue_op,
    input  exec_pkg::id_t         issue_id,
    input  exec_pkg::reg_addr_t   issue_rd,
    input  exec_pkg::data_t       issue_rs1,
    input  exec_pkg::data_t       issue_rs2,
    output logic                  issue_ready,
    unit_issue_if.dispatch        alu_issue,
    unit_issue_if.dispatch        mul_issue
);
    import exec_pkg::*;

    logic to_mul;

    assign to_mul = (issue_unit == UNIT_MUL);

    // Request only goes to the selected unit, and only when it can take it
    assign alu_issue.new_request = issue_valid && !to_mul && alu_issue.ready;
    assign mul_issue.new_request = issue_valid && to_mul && mul_issue.ready;

    assign issue_ready = (issue_unit == UNIT_ALU) ? alu_issue.ready : mul_issue.ready;

    // Instruction fields are shared
    assign alu_issue.id  = issue_id;
    assign alu_issue.rd  = issue_rd;
    assign alu_issue.op  = issue_op;
    assign alu_issue.rs1 = issue_rs1;
    assign alu_issue.rs2 = issue_rs2;

    assign mul_issue.id  = issue_id;
    assign mul_issue.rd  = issue_rd;
    assign mul_issue.op  = issue_op;
    assign mul_issue.rs1 = issue_rs1;
    assign mul_issue.rs2 = issue_rs2;

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU with one result register.
// A held result blocks new work until writeback acks it; an ack and
// a new request in the same cycle keep the unit busy back to back.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module alu_unit (
    input  logic        clk,
    input  logic        reset,
    unit_issue_if.unit  issue,
    unit_wb_if.unit     wb
);
    import exec_pkg::*;

    data_t alu_result;
    logic [$clog2(XLEN)-1:0] shamt;

    assign shamt = issue.rs2[$clog2(XLEN)-1:0];

    always_comb begin
        case (issue.op)
            ALU_ADD: alu_result = issue.rs1 + issue.rs2;
            ALU_SUB: alu_result = issue.rs1 - issue.rs2;
            ALU_AND: alu_result = issue.rs1 & issue.rs2;
            ALU_OR:  alu_result = issue.rs1 | issue.rs2;
            ALU_XOR: alu_result = issue.rs1 ^ issue.rs2;
            ALU_SLL: alu_result = issue.rs1 << shamt;
            ALU_SRL: alu_result = issue.rs1 >> shamt;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(issue.rs1) < $signed(issue.rs2)};
        endcase
    end

    // Free when empty, or when the held result leaves this cycle
    assign issue.ready = !wb.done || wb.ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb.done <= 1'b0;
        end else if (issue.new_request) begin
            wb.done <= 1'b1;
        end else if (wb.ack) begin
            wb.done <= 1'b0;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (issue.new_request) begin
            wb.rd_data <= alu_result;
            wb.id <= issue.id;
            wb.rd <= issue.rd;
        end
    end

    request_only_when_ready: assert property (
        @(posedge clk) disable iff (reset) issue.new_request |-> issue.ready);

endmodule

`default_nettype wire

// ==== mul_unit.sv ====
//////////////////////////////////////////////////////////////////////
// Three-stage unsigned multiplier, done three edges after accept.
// The whole pipeline freezes while the last stage holds an unacked
// result, so up to three instructions are in flight.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module mul_unit (
    input  logic        clk,
    input  logic        reset,
    unit_issue_if.unit  issue,
    unit_wb_if.unit     wb
);
    import exec_pkg::*;

    logic [MUL_STAGES-1:0] stage_valid;
    logic advance;

    // Stage one, registered operands
    data_t s1_rs1;
    data_t s1_rs2;
    op_t s1_op;
    id_t s1_id;
    reg_addr_t s1_rd;

    // Stage two, full product
    logic [2*XLEN-1:0] s2_product;
    op_t s2_op;
    id_t s2_id;
    reg_addr_t s2_rd;

    assign advance = !stage_valid[MUL_STAGES-1] || wb.ack;
    assign issue.ready = advance;
    assign wb.done = stage_valid[MUL_STAGES-1];

    ////////////////////////////////////////////////////////////////////
    // Pipeline control
    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[MUL_STAGES-2:0], issue.new_request};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Datapath
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_rs1 <= issue.rs1;
            s1_rs2 <= issue.rs2;
            s1_op <= issue.op;
            s1_id <= issue.id;
            s1_rd <= issue.rd;

            s2_product <= (2*XLEN)'(s1_rs1) * (2*XLEN)'(s1_rs2);
            s2_op <= s1_op;
            s2_id <= s1_id;
            s2_rd <= s1_rd;

            // Word select
            wb.rd_data <= (s2_op == MUL_HU) ? s2_product[2*XLEN-1:XLEN] : s2_product[XLEN-1:0];
            wb.id <= s2_id;
            wb.rd <= s2_rd;
        end
    end

    held_result_stable: assert property (
        @(posedge clk) disable iff (reset)
        wb.done && !wb.ack |=> wb.done && $stable(wb.rd_data) && $stable(wb.id)
            && $stable(wb.rd));

endmodule

`default_nettype wire

// ==== writeback.sv ====
//////////////////////////////////////////////////////////////////////
// Single writeback port, fixed priority with the multiplier first.
// The winner is acked in its done cycle and shows up as a one-cycle
// wb_valid pulse on the next edge. No back-pressure from outside.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module writeback (
    input  logic                  clk,
    input  logic                  reset,
    unit_wb_if.writeback          alu_wb,
    unit_wb_if.writeback          mul_wb,
    output logic                  wb_valid,
    output exec_pkg::id_t         wb_id,
    output exec_pkg::reg_addr_t   wb_rd,
    output exec_pkg::data_t       wb_data
);
    import exec_pkg::*;

    id_t sel_id;
    reg_addr_t sel_rd;
    data_t sel_data;

    // Multiplier wins, so its pipeline never stays frozen for long
    assign mul_wb.ack = mul_wb.done;
    assign alu_wb.ack = alu_wb.done && !mul_wb.done;

    always_comb begin
        if (mul_wb.done) begin
            sel_id = mul_wb.id;
            sel_rd = mul_wb.rd;
            sel_data = mul_wb.rd_data;
        end else begin
            sel_id = alu_wb.id;
            sel_rd = alu_wb.rd;
            sel_data = alu_wb.rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= alu_wb.done || mul_wb.done;
        end
    end

    // Commit packet
    always_ff @(posedge clk) begin
        wb_id <= sel_id;
        wb_rd <= sel_rd;
        wb_data <= sel_data;
    end

    // An ALU result that loses to the multiplier waits unchanged
    alu_held_while_waiting: assert property (
        @(posedge clk) disable iff (reset)
        alu_wb.done && !alu_wb.ack |=> alu_wb.done && $stable(alu_wb.id)
            && $stable(alu_wb.rd) && $stable(alu_wb.rd_data));

endmodule

`default_nettype wire

// ==== register_file.sv ====
//////////////////////////////////////////////////////////////////////
// 32 x 32 register file, one write port from writeback and one
// combinational read port. Register 0 is never written.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wb_valid,
    input  exec_pkg::reg_addr_t   wb_rd,
    input  exec_pkg::data_t       wb_data,
    input  exec_pkg::reg_addr_t   read_addr,
    output exec_pkg::data_t       read_data
);
    import exec_pkg::*;

    data_t regs [2**REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_WIDTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Visible from the edge after the write
    assign read_data = regs[read_addr];

    zero_reg_stays_zero: assert property (
        @(posedge clk) disable iff (reset) regs[0] == '0);

endmodule

`default_nettype wire

// ==== exec_core.sv ====
//////////////////////////////////////////////////////////////////////
// Execution slice top. Ids come from outside and must not be reused
// while in flight. Results leave on wb_valid, in completion order.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module exec_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue_valid,
    input  exec_pkg::unit_sel_t   issue_unit,
    input  exec_pkg::op_t         issue_op,
    input  exec_pkg::id_t         issue_id,
    input  exec_pkg::reg_addr_t   issue_rd,
    input  exec_pkg::data_t       issue_rs1,
    input  exec_pkg::data_t       issue_rs2,
    input  exec_pkg::reg_addr_t   rf_read_addr,
    output logic                  issue_ready,
    output logic                  wb_valid,
    output exec_pkg::id_t         wb_id,
    output exec_pkg::reg_addr_t   wb_rd,
    output exec_pkg::data_t       wb_data,
    output exec_pkg::data_t       rf_read_data
);

    unit_issue_if alu_issue ();
    unit_issue_if mul_issue ();
    unit_wb_if alu_wb ();
    unit_wb_if mul_wb ();

    ////////////////////////////////////////////////////////////////////
    // Issue
    issue_dispatch dispatch_block (
        .issue_valid (issue_valid),
        .issue_unit  (issue_unit),
        .issue_op    (issue_op),
        .issue_id    (issue_id),
        .issue_rd    (issue_rd),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_ready (issue_ready),
        .alu_issue   (alu_issue),
        .mul_issue   (mul_issue)
    );

    ////////////////////////////////////////////////////////////////////
    // Execution units
    alu_unit alu_unit_block (.clk(clk), .reset(reset), .issue(alu_issue), .wb(alu_wb));
    mul_unit mul_unit_block (.clk(clk), .reset(reset), .issue(mul_issue), .wb(mul_wb));

    ////////////////////////////////////////////////////////////////////
    // Writeback and commit
    writeback writeback_block (
        .clk      (clk),
        .reset    (reset),
        .alu_wb   (alu_wb),
        .mul_wb   (mul_wb),
        .wb_valid (wb_valid),
        .wb_id    (wb_id),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    register_file register_file_block (
        .clk       (clk),
        .reset     (reset),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .read_addr (rf_read_addr),
        .read_data (rf_read_data)
    );

endmodule

`default_nettype wire

// ==== exec_core_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the execution slice. Ids rotate over
// all 16 values and skip any id still in flight. Expected results sit
// in a table indexed by id and are compared by concurrent assertions.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module exec_core_tb;
    import exec_pkg::*;

    localparam int MIXED_COUNT = 40;
    localparam int TOTAL_INSTR = 8 + 2 + MUL_STAGES + MIXED_COUNT;
    localparam int TIMEOUT_CYCLES = 16 + 8 * TOTAL_INSTR + 50;
    localparam int NUM_IDS = 2**ID_WIDTH;

    logic clk;
    logic reset;
    logic issue_valid;
    unit_sel_t issue_unit;
    op_t issue_op;
    id_t issue_id;
    reg_addr_t issue_rd;
    data_t issue_rs1;
    data_t issue_rs2;
    reg_addr_t rf_read_addr = '0;
    logic issue_ready;
    logic wb_valid;
    id_t wb_id;
    reg_addr_t wb_rd;
    data_t wb_data;
    data_t rf_read_data;

    // Reference model, one entry per id
    logic [NUM_IDS-1:0] in_flight = '0;
    reg_addr_t exp_rd [NUM_IDS];
    data_t exp_data [NUM_IDS];
    int exp_lat [NUM_IDS];
    int accept_cycle [NUM_IDS];

    int cycle = 0;
    int error_count = 0;
    int test_count = 0;
    int test_start_errors = 0;
    string test_name = "reset_state";
    logic [31:0] lcg_state = 32'hb897_8698;
    id_t next_id = '0;
    logic isolated = 1'b0;
    logic scanning = 1'b0;
    logic commit_check = 1'b0;
    reg_addr_t last_rd = '0;
    data_t last_data = '0;

    exec_core dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic data_t expected_result(unit_sel_t unit, op_t op, data_t a, data_t b);
        logic [63:0] product;
        product = {32'd0, a} * {32'd0, b};
        if (unit == UNIT_MUL) begin
            return (op == MUL_HU) ? product[63:32] : product[31:0];
        end
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            // Signed compare from the sign bits first
            ALU_SLT: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic id_t pick_id();
        id_t id;
        while (in_flight[next_id]) begin
            next_id = next_id + 1'b1;
        end
        id = next_id;
        next_id = next_id + 1'b1;
        return id;
    endfunction

    // Starts at a clock edge and returns at the edge that accepts it
    task automatic send(input unit_sel_t unit, input op_t op, input reg_addr_t rd,
                        input data_t a, input data_t b);
        issue_valid <= 1'b1;
        issue_unit <= unit;
        issue_op <= op;
        issue_id <= pick_id();
        issue_rd <= rd;
        issue_rs1 <= a;
        issue_rs2 <= b;
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        issue_valid <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clk);
        while (in_flight != '0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_start_errors = error_count;
    endtask

    task automatic finish_test();
        test_count++;
        $display("[%0s] finished with %0d errors", test_name, error_count - test_start_errors);
    endtask

    ////////////////////////////////////////////////////////////////////
    // Model update and register readback
    always @(posedge clk) begin
        cycle <= cycle + 1;
        commit_check <= wb_valid && !reset;
        if (wb_valid) begin
            in_flight[wb_id] <= 1'b0;
            last_rd <= exp_rd[wb_id];
            last_data <= exp_data[wb_id];
            rf_read_addr <= exp_rd[wb_id];
        end else if (scanning) begin
            rf_read_addr <= rf_read_addr + 1'b1;
        end
        if (issue_valid && issue_ready && !reset) begin
            in_flight[issue_id] <= 1'b1;
            exp_rd[issue_id] <= issue_rd;
            exp_data[issue_id] <= expected_result(issue_unit, issue_op, issue_rs1, issue_rs2);
            exp_lat[issue_id] <= (issue_unit == UNIT_MUL) ? MUL_STAGES + 1 : 2;
            accept_cycle[issue_id] <= cycle;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    reset_rf_zero: assert property (@(posedge clk) scanning |-> rf_read_data == '0)
        else begin
            $display("MISMATCH %s rf[%0d] expected %h actual %h", test_name,
                     $sampled(rf_read_addr), 32'h0, $sampled(rf_read_data));
            error_count++;
        end

    reset_idle: assert property (@(posedge clk) scanning |-> !wb_valid && issue_ready)
        else begin
            $display("%s: wb_valid high or issue_ready low after reset", test_name);
            error_count++;
        end

    wb_known_id: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> in_flight[wb_id])
        else begin
            $display("%s: wb_valid carried id %0d, which is not in flight", test_name,
                     $sampled(wb_id));
            error_count++;
        end

    wb_rd_match: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_rd == exp_rd[wb_id])
        else begin
            $display("MISMATCH %s id %0d rd expected %0d actual %0d", test_name,
                     $sampled(wb_id), exp_rd[$sampled(wb_id)], $sampled(wb_rd));
            error_count++;
        end

    wb_data_match: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_data == exp_data[wb_id])
        else begin
            $display("MISMATCH %s id %0d data expected %h actual %h", test_name,
                     $sampled(wb_id), exp_data[$sampled(wb_id)], $sampled(wb_data));
            error_count++;
        end

    // Only with nothing competing for the units or writeback
    wb_latency: assert property (@(posedge clk) disable iff (reset)
        isolated && wb_valid |-> cycle - accept_cycle[wb_id] == exp_lat[wb_id])
        else begin
            $display("MISMATCH %s id %0d latency expected %0d actual %0d", test_name,
                     $sampled(wb_id), exp_lat[$sampled(wb_id)],
                     $sampled(cycle) - accept_cycle[$sampled(wb_id)]);
            error_count++;
        end

    isolated_ready: assert property (@(posedge clk) disable iff (reset)
        isolated && issue_valid |-> issue_ready)
        else begin
            $display("%s: a unit refused an instruction with nothing competing", test_name);
            error_count++;
        end

    commit_visible: assert property (@(posedge clk) disable iff (reset)
        commit_check |-> rf_read_data == ((last_rd == '0) ? '0 : last_data))
        else begin
            $display("MISMATCH %s rf[%0d] expected %h actual %h", test_name,
                     $sampled(last_rd), ($sampled(last_rd) == '0) ? '0 : $sampled(last_data),
                     $sampled(rf_read_data));
            error_count++;
        end

    ////////////////////////////////////////////////////////////////////
    // Stimulus
    initial begin
        logic [31:0] r;
        unit_sel_t unit;
        op_t op;
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_unit = UNIT_ALU;
        issue_op = '0;
        issue_id = '0;
        issue_rd = '0;
        issue_rs1 = '0;
        issue_rs2 = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // One register per cycle
        start_test("reset_state");
        scanning <= 1'b1;
        repeat (2**REG_ADDR_WIDTH) @(posedge clk);
        scanning <= 1'b0;
        finish_test();

        start_test("alu_ops");
        isolated <= 1'b1;
        for (int i = 0; i < 8; i++) begin
            send(UNIT_ALU, op_t'(i), reg_addr_t'(i), next_random(), next_random());
            drain();
        end
        finish_test();

        start_test("mul_ops");
        send(UNIT_MUL, MUL_LO, 5'd9, 32'hffff_fffe, 32'h0000_0003);
        drain();
        send(UNIT_MUL, MUL_HU, 5'd10, 32'hffff_fffe, 32'h0000_0003);
        drain();
        for (int i = 0; i < MUL_STAGES; i++) begin
            send(UNIT_MUL, op_t'(i % 2), reg_addr_t'(11 + i), next_random(), next_random());
        end
        drain();
        isolated <= 1'b0;
        finish_test();

        start_test("mixed_stream");
        for (int i = 0; i < MIXED_COUNT; i++) begin
            r = next_random();
            unit = r[31];
            op = (unit == UNIT_MUL) ? {2'b00, r[27]} : r[30:28];
            send(unit, op, r[26:22], next_random(), next_random());
            repeat (r[21:20]) @(posedge clk);
        end
        drain();
        finish_test();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles, the DUT stopped making progress", cycle);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
exec_pkg.sv
unit_issue_if.sv
unit_wb_if.sv
issue_dispatch.sv
alu_unit.sv
mul_unit.sv
writeback.sv
register_file.sv
exec_core.sv
exec_core_tb.sv

// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - exec_pkg.sv
  - unit_issue_if.sv
  - unit_wb_if.sv
  - issue_dispatch.sv
  - alu_unit.sv
  - mul_unit.sv
  - writeback.sv
  - register_file.sv
  - exec_core.sv
  - target: test
    files:
      - exec_core_tb.sv
